// File: design/blocking_cache.sv
//------------------
// Blocking cache top, FSM plus datapath
//------------------

`timescale 1ns/1ps
`default_nettype none

`include "cache_consts.svh"

module blocking_cache (
  input  logic                        clk,
  input  logic                        reset,

  input  logic                        cachereq_val,
  output logic                        cachereq_rdy,
  input  cache_msg_pkg::cache_req_t   cachereq_msg,

  output logic                        cacheresp_val,
  input  logic                        cacheresp_rdy,
  output cache_msg_pkg::cache_resp_t  cacheresp_msg,

  output logic                        memreq_val,
  input  logic                        memreq_rdy,
  output cache_msg_pkg::mem_req_t     memreq_msg,

  input  logic                        memresp_val,
  output logic                        memresp_rdy,
  input  cache_msg_pkg::mem_resp_t    memresp_msg
);

  cache_ctrl_pkg::ctrl_t     ctrl;
  cache_ctrl_pkg::lookup_t   lookup;
  cache_msg_pkg::req_type_e  req_type;

  cache_ctrl ctrl_i (
    .clk           (clk),
    .reset         (reset),
    .cachereq_val  (cachereq_val),
    .cachereq_rdy  (cachereq_rdy),
    .cacheresp_val (cacheresp_val),
    .cacheresp_rdy (cacheresp_rdy),
    .memreq_val    (memreq_val),
    .memreq_rdy    (memreq_rdy),
    .memresp_val   (memresp_val),
    .memresp_rdy   (memresp_rdy),
    .req_type      (req_type),
    .lookup        (lookup),
    .ctrl          (ctrl)
  );

  cache_dpath dpath_i (
    .clk           (clk),
    .reset         (reset),
    .cachereq_msg  (cachereq_msg),
    .cacheresp_msg (cacheresp_msg),
    .memreq_msg    (memreq_msg),
    .memresp_msg   (memresp_msg),
    .ctrl          (ctrl),
    .lookup        (lookup),
    .req_type      (req_type)
  );

endmodule

`default_nettype wire

// File: design/cache_ctrl.sv
//------------------
// Request FSM and control table of the blocking cache
//------------------

`timescale 1ns/1ps
`default_nettype none

`include "cache_consts.svh"

module cache_ctrl (
  input  logic                      clk,
  input  logic                      reset,

  input  logic                      cachereq_val,
  output logic                      cachereq_rdy,
  output logic                      cacheresp_val,
  input  logic                      cacheresp_rdy,
  output logic                      memreq_val,
  input  logic                      memreq_rdy,
  input  logic                      memresp_val,
  output logic                      memresp_rdy,

  input  cache_msg_pkg::req_type_e  req_type,
  input  cache_ctrl_pkg::lookup_t   lookup,
  output cache_ctrl_pkg::ctrl_t     ctrl
);

  cache_ctrl_pkg::state_e state;
  cache_ctrl_pkg::state_e state_next;

  logic is_init;
  logic is_write;

  assign is_init  = (req_type == cache_msg_pkg::req_init);
  assign is_write = (req_type == cache_msg_pkg::req_write);

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= cache_ctrl_pkg::idle;
    end else begin
      state <= state_next;
    end
  end

  //------------------
  // Next state
  //------------------

  always_comb begin
    state_next = state;
    case (state)
      cache_ctrl_pkg::idle: begin
        if (cachereq_val) state_next = cache_ctrl_pkg::tag_check;
      end
      cache_ctrl_pkg::tag_check: begin
        if (is_init || lookup.hit) begin
          state_next = cache_ctrl_pkg::access;
        end else if (lookup.victim_dirty) begin
          state_next = cache_ctrl_pkg::evict_req;
        end else begin
          state_next = cache_ctrl_pkg::refill_req;
        end
      end
      cache_ctrl_pkg::access:        state_next = cache_ctrl_pkg::resp_wait;
      cache_ctrl_pkg::evict_req: begin
        if (memreq_rdy) state_next = cache_ctrl_pkg::evict_wait;
      end
      cache_ctrl_pkg::evict_wait: begin
        if (memresp_val) state_next = cache_ctrl_pkg::refill_req;
      end
      cache_ctrl_pkg::refill_req: begin
        if (memreq_rdy) state_next = cache_ctrl_pkg::refill_wait;
      end
      cache_ctrl_pkg::refill_wait: begin
        if (memresp_val) state_next = cache_ctrl_pkg::refill_update;
      end
      cache_ctrl_pkg::refill_update: state_next = cache_ctrl_pkg::access;
      cache_ctrl_pkg::resp_wait: begin
        if (cacheresp_rdy) state_next = cache_ctrl_pkg::idle;
      end
      default:                       state_next = cache_ctrl_pkg::idle;
    endcase
  end

  //------------------
  // Control table
  //------------------

  always_comb begin
    cachereq_rdy  = 1'b0;
    cacheresp_val = 1'b0;
    memreq_val    = 1'b0;
    memresp_rdy   = 1'b0;
    ctrl          = '0;
    case (state)
      cache_ctrl_pkg::idle: begin
        cachereq_rdy = 1'b1;
        ctrl.req_en  = cachereq_val;
      end
      cache_ctrl_pkg::tag_check: ctrl.lookup_en = 1'b1;
      cache_ctrl_pkg::access: begin
        // Only an init miss gets here without a hit
        ctrl.way_sel_victim  = !lookup.hit;
        ctrl.tag_write       = is_init && !lookup.hit;
        ctrl.data_write_word = is_init || is_write;
        ctrl.mark_dirty      = is_write;
        ctrl.lru_touch       = 1'b1;
        ctrl.resp_en         = 1'b1;
      end
      cache_ctrl_pkg::evict_req: begin
        memreq_val          = 1'b1;
        ctrl.way_sel_victim = 1'b1;
        ctrl.memreq_evict   = 1'b1;   // Old line goes out
      end
      cache_ctrl_pkg::evict_wait:  memresp_rdy = 1'b1;
      cache_ctrl_pkg::refill_req:  memreq_val  = 1'b1;
      cache_ctrl_pkg::refill_wait: begin
        memresp_rdy          = 1'b1;
        ctrl.way_sel_victim  = 1'b1;
        ctrl.data_write_line = memresp_val;   // Line lands on the transfer edge
      end
      cache_ctrl_pkg::refill_update: begin
        ctrl.way_sel_victim = 1'b1;
        ctrl.tag_write      = 1'b1;
      end
      cache_ctrl_pkg::resp_wait: cacheresp_val = 1'b1;
      default: begin
      end
    endcase
  end

  // A raised memory request is held until taken
  memreq_held: assert property (@(posedge clk) disable iff (reset)
    memreq_val && !memreq_rdy |=> memreq_val);

endmodule

`default_nettype wire

// File: design/cache_ctrl_pkg.sv
//------------------
// FSM states and controller/datapath bundles
//------------------

`default_nettype none

`include "cache_consts.svh"

package cache_ctrl_pkg;

  typedef enum logic [3:0] {
    idle          = 4'd0,
    tag_check     = 4'd1,
    access        = 4'd2,
    evict_req     = 4'd3,
    evict_wait    = 4'd4,
    refill_req    = 4'd5,
    refill_wait   = 4'd6,
    refill_update = 4'd7,
    resp_wait     = 4'd8
  } state_e;

  // Tag lookup result for the current set
  typedef struct packed {
    logic                    hit;
    logic                    hit_way;
    logic                    victim_way;
    logic                    victim_dirty;
    logic [`CACHE_TAG_W-1:0] victim_tag;
  } lookup_t;

  // Per-cycle commands from the FSM
  typedef struct packed {
    logic req_en;           // Capture incoming request
    logic lookup_en;        // Capture hit flag
    logic way_sel_victim;   // Act on victim way instead of hit way
    logic tag_write;
    logic data_write_word;
    logic data_write_line;
    logic mark_dirty;
    logic lru_touch;
    logic memreq_evict;     // Memory request is a writeback
    logic resp_en;          // Capture response data
  } ctrl_t;

endpackage

`default_nettype wire

// File: design/cache_data_array.sv
//------------------
// Line storage for both ways, word and line writes
//------------------

`timescale 1ns/1ps
`default_nettype none

`include "cache_consts.svh"

module cache_data_array (
  input  logic                     clk,
  input  logic [`CACHE_IDX_W-1:0]  index,
  input  logic                     way,
  input  logic [`CACHE_WSEL_W-1:0] word_sel,
  input  logic [`CACHE_DATA_W-1:0] word_data,
  input  logic [`CACHE_LINE_W-1:0] line_data,
  input  logic                     write_word,
  input  logic                     write_line,
  input  logic                     zero_fill,
  output logic [`CACHE_LINE_W-1:0] rd_line,
  output logic [`CACHE_DATA_W-1:0] rd_word
);

  logic [`CACHE_LINE_W-1:0] lines [`CACHE_WAYS][`CACHE_SETS];
  logic [`CACHE_LINE_W-1:0] merged;

  assign rd_line = lines[way][index];
  assign rd_word = rd_line[word_sel*`CACHE_DATA_W +: `CACHE_DATA_W];

  // Old line with one word replaced, or a zeroed line for init
  always_comb begin
    merged = zero_fill ? '0 : rd_line;
    merged[word_sel*`CACHE_DATA_W +: `CACHE_DATA_W] = word_data;
  end

  always_ff @(posedge clk) begin
    if (write_line) begin
      lines[way][index] <= line_data;
    end else if (write_word) begin
      lines[way][index] <= merged;
    end
  end

  // Refill and word access happen in different FSM states
  one_write: assert property (@(posedge clk) !(write_word && write_line));

endmodule

`default_nettype wire

// File: design/cache_dpath.sv
//------------------
// Request register, address split, memory and response messages
//------------------

`timescale 1ns/1ps
`default_nettype none

`include "cache_consts.svh"

module cache_dpath (
  input  logic                        clk,
  input  logic                        reset,
  input  cache_msg_pkg::cache_req_t   cachereq_msg,
  output cache_msg_pkg::cache_resp_t  cacheresp_msg,
  output cache_msg_pkg::mem_req_t     memreq_msg,
  input  cache_msg_pkg::mem_resp_t    memresp_msg,
  input  cache_ctrl_pkg::ctrl_t       ctrl,
  output cache_ctrl_pkg::lookup_t     lookup,
  output cache_msg_pkg::req_type_e    req_type
);

  cache_msg_pkg::cache_req_t  req_reg;
  logic                       hit_reg;
  logic [`CACHE_DATA_W-1:0]   resp_data;

  logic [`CACHE_TAG_W-1:0]    addr_tag;
  logic [`CACHE_IDX_W-1:0]    addr_idx;
  logic [`CACHE_WSEL_W-1:0]   addr_wsel;
  logic                       active_way;
  logic                       zero_fill;
  logic [`CACHE_LINE_W-1:0]   rd_line;
  logic [`CACHE_DATA_W-1:0]   rd_word;

  // Request and response payload registers
  always_ff @(posedge clk) begin
    if (ctrl.req_en) req_reg <= cachereq_msg;
    if (ctrl.lookup_en) hit_reg <= lookup.hit;   // Hit as seen at tag check
    if (ctrl.resp_en) begin
      resp_data <= (req_reg.req_type == cache_msg_pkg::req_read) ? rd_word : '0;
    end
  end

  assign req_type   = req_reg.req_type;
  assign addr_tag   = req_reg.addr[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
  assign addr_idx   = req_reg.addr[`CACHE_OFS_W +: `CACHE_IDX_W];
  assign addr_wsel  = req_reg.addr[`CACHE_OFS_W-1 -: `CACHE_WSEL_W];
  assign active_way = ctrl.way_sel_victim ? lookup.victim_way : lookup.hit_way;
  assign zero_fill  = (req_reg.req_type == cache_msg_pkg::req_init);

  cache_tag_array tag_i (
    .clk        (clk),
    .reset      (reset),
    .index      (addr_idx),
    .tag        (addr_tag),
    .way        (active_way),
    .tag_write  (ctrl.tag_write),
    .mark_dirty (ctrl.mark_dirty),
    .lru_touch  (ctrl.lru_touch),
    .lookup     (lookup)
  );

  cache_data_array data_i (
    .clk        (clk),
    .index      (addr_idx),
    .way        (active_way),
    .word_sel   (addr_wsel),
    .word_data  (req_reg.data),
    .line_data  (memresp_msg.data),
    .write_word (ctrl.data_write_word),
    .write_line (ctrl.data_write_line),
    .zero_fill  (zero_fill),
    .rd_line    (rd_line),
    .rd_word    (rd_word)
  );

  //------------------
  // Memory request
  //------------------

  always_comb begin
    if (ctrl.memreq_evict) begin
      memreq_msg.mem_type = cache_msg_pkg::mem_write;
      memreq_msg.addr     = {lookup.victim_tag, addr_idx, {`CACHE_OFS_W{1'b0}}};
      memreq_msg.data     = rd_line;
    end else begin
      memreq_msg.mem_type = cache_msg_pkg::mem_read;
      memreq_msg.addr     = {addr_tag, addr_idx, {`CACHE_OFS_W{1'b0}}};
      memreq_msg.data     = '0;
    end
  end

  assign cacheresp_msg.req_type = req_reg.req_type;
  assign cacheresp_msg.data     = resp_data;
  assign cacheresp_msg.hit      = hit_reg;

endmodule

`default_nettype wire

// File: design/cache_msg_pkg.sv
//------------------
// Message types for the cache and memory ports
//------------------

`default_nettype none

`include "cache_consts.svh"

package cache_msg_pkg;

  // Request kinds on the cache port
  typedef enum logic [1:0] {
    req_read  = 2'd0,
    req_write = 2'd1,
    req_init  = 2'd2
  } req_type_e;

  typedef struct packed {
    req_type_e                req_type;
    logic [`CACHE_ADDR_W-1:0] addr;
    logic [`CACHE_DATA_W-1:0] data;     // Write data, also init data
  } cache_req_t;

  typedef struct packed {
    req_type_e                req_type;
    logic [`CACHE_DATA_W-1:0] data;     // Zero unless read
    logic                     hit;
  } cache_resp_t;

  // Line transfers to and from memory
  typedef enum logic {
    mem_read  = 1'b0,
    mem_write = 1'b1
  } mem_type_e;

  typedef struct packed {
    mem_type_e                mem_type;
    logic [`CACHE_ADDR_W-1:0] addr;     // Line aligned
    logic [`CACHE_LINE_W-1:0] data;
  } mem_req_t;

  typedef struct packed {
    mem_type_e                mem_type;
    logic [`CACHE_LINE_W-1:0] data;
  } mem_resp_t;

endpackage

`default_nettype wire

// File: design/cache_tag_array.sv
//------------------
// Tags, valid, dirty and LRU state with hit and victim lookup
//------------------

`timescale 1ns/1ps
`default_nettype none

`include "cache_consts.svh"

module cache_tag_array (
  input  logic                     clk,
  input  logic                     reset,
  input  logic [`CACHE_IDX_W-1:0]  index,
  input  logic [`CACHE_TAG_W-1:0]  tag,
  input  logic                     way,
  input  logic                     tag_write,
  input  logic                     mark_dirty,
  input  logic                     lru_touch,
  output cache_ctrl_pkg::lookup_t  lookup
);

  logic [`CACHE_TAG_W-1:0]                  tags [`CACHE_WAYS][`CACHE_SETS];
  logic [`CACHE_SETS-1:0][`CACHE_WAYS-1:0]  valid;
  logic [`CACHE_SETS-1:0][`CACHE_WAYS-1:0]  dirty;
  logic [`CACHE_SETS-1:0]                   lru;     // Way to replace next

  logic [`CACHE_WAYS-1:0] match;
  logic                   victim;

  //------------------
  // Lookup
  //------------------

  always_comb begin
    for (int w = 0; w < `CACHE_WAYS; w++) begin
      match[w] = valid[index][w] && (tags[w][index] == tag);
    end
  end

  // Empty way first, else the LRU way
  always_comb begin
    if (!valid[index][0]) begin
      victim = 1'b0;
    end else if (!valid[index][1]) begin
      victim = 1'b1;
    end else begin
      victim = lru[index];
    end
  end

  assign lookup.hit          = |match;
  assign lookup.hit_way      = match[1];
  assign lookup.victim_way   = victim;
  assign lookup.victim_dirty = valid[index][victim] && dirty[index][victim];
  assign lookup.victim_tag   = tags[victim][index];

  //------------------
  // Updates
  //------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      valid <= '0;
      dirty <= '0;
      lru   <= '0;
    end else begin
      if (tag_write) begin
        valid[index][way] <= 1'b1;
        dirty[index][way] <= 1'b0;   // Fresh line
      end
      if (mark_dirty) dirty[index][way] <= 1'b1;
      if (lru_touch) lru[index] <= ~way;
    end
  end

  always_ff @(posedge clk) begin
    if (tag_write) tags[way][index] <= tag;
  end

  // Installs only go to a missing tag, so one set never holds it twice
  unique_match: assert property (@(posedge clk) disable iff (reset)
    !(match[0] && match[1]));

endmodule

`default_nettype wire

// File: include/cache_consts.svh
//------------------
// Cache geometry and field widths
//------------------

`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

// Bus widths
`define CACHE_ADDR_W  32
`define CACHE_DATA_W  32
`define CACHE_LINE_W  128

// Organization
`define CACHE_WORDS   4   // Words per line
`define CACHE_SETS    8
`define CACHE_WAYS    2

// Address fields
`define CACHE_OFS_W   4   // Byte offset within a line
`define CACHE_IDX_W   3
`define CACHE_TAG_W   (`CACHE_ADDR_W - `CACHE_IDX_W - `CACHE_OFS_W)
`define CACHE_WSEL_W  2   // Word select within a line

`endif

// File: list.f
+incdir+include
design/cache_msg_pkg.sv
design/cache_ctrl_pkg.sv
design/cache_tag_array.sv
design/cache_data_array.sv
design/cache_ctrl.sv
design/cache_dpath.sv
design/blocking_cache.sv
tb/cache_mem_model.sv
tb/cache_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build the cache testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 \
  --top-module cache_tb \
  -f list.f \
  -Mdir obj_dir
./obj_dir/Vcache_tb

// File: tb/cache_cases.txt
# name kind addr wdata exp_data exp_hit, hex except exp_hit
# kind wb checks the next writeback: addr is its line, wdata the written word's address
rd_cold        read  00001004 00000000 a5a51004 0
rd_adjacent    read  00001008 00000000 a5a51008 1
wr_hit         write 0000100c deadbeef 00000000 1
rd_after_wr    read  0000100c 00000000 deadbeef 1
init_cold      init  00002014 12345678 00000000 0
rd_init        read  00002014 00000000 12345678 1
rd_init_zero   read  00002018 00000000 00000000 1
lru_fill_a     read  00003020 00000000 a5a53020 0
lru_fill_b     read  00003120 00000000 a5a53120 0
lru_touch_a    read  00003024 00000000 a5a53024 1
lru_miss_c     read  00003220 00000000 a5a53220 0
lru_keep_a     read  00003028 00000000 a5a53028 1
lru_lost_b     read  0000312c 00000000 a5a5312c 0
ev_miss_1      read  00001100 00000000 a5a51100 0
ev_miss_2      read  00001200 00000000 a5a51200 0
ev_log         wb    00001000 0000100c deadbeef 0
ev_reload      read  0000100c 00000000 deadbeef 0
wr_miss        write 00004044 cafef00d 00000000 0
rd_wr_miss     read  00004044 00000000 cafef00d 1
rd_wr_miss_nb  read  00004040 00000000 a5a54040 1
init_hit       init  00004048 11112222 00000000 1
rd_init_hit    read  00004044 00000000 00000000 1

// File: tb/cache_mem_model.sv
//------------------
// Line memory with random response delay and writeback log
//------------------

`timescale 1ns/1ps
`default_nettype none

`include "cache_consts.svh"

module cache_mem_model (
  input  logic                      clk,
  input  logic                      memreq_val,
  output logic                      memreq_rdy,
  input  cache_msg_pkg::mem_req_t   memreq_msg,
  output logic                      memresp_val,
  input  logic                      memresp_rdy,
  output cache_msg_pkg::mem_resp_t  memresp_msg,
  output logic                      cacheresp_rdy
);

  localparam logic [`CACHE_DATA_W-1:0] FILL_KEY = 32'hA5A5_0000;
  localparam int LOG_DEPTH = 16;

  integer                   seed;
  logic [`CACHE_LINE_W-1:0] lines [logic [`CACHE_ADDR_W-1:0]];   // Written-back lines
  cache_msg_pkg::mem_req_t  wb_log [LOG_DEPTH];
  int                       wb_count;
  logic                     busy;
  logic                     resp_taken;
  int                       delay;

  // Untouched words hold their own address XOR the key
  function automatic logic [`CACHE_LINE_W-1:0] line_at(input logic [`CACHE_ADDR_W-1:0] addr);
    logic [`CACHE_LINE_W-1:0] line;
    logic [`CACHE_ADDR_W-1:0] word_addr;
    if (lines.exists(addr)) return lines[addr];
    for (int i = 0; i < `CACHE_WORDS; i++) begin
      word_addr = addr + 4 * i;
      line[i*`CACHE_DATA_W +: `CACHE_DATA_W] = word_addr ^ FILL_KEY;
    end
    return line;
  endfunction

  task automatic accept_request(input cache_msg_pkg::mem_req_t req);
    if (req.mem_type == cache_msg_pkg::mem_write) begin
      lines[req.addr] = req.data;
      if (wb_count < LOG_DEPTH) wb_log[wb_count] = req;
      wb_count++;
      memresp_msg.mem_type = cache_msg_pkg::mem_write;
      memresp_msg.data     = '0;
    end else begin
      memresp_msg.mem_type = cache_msg_pkg::mem_read;
      memresp_msg.data     = line_at(req.addr);
    end
    busy  = 1'b1;
    delay = $unsigned($random(seed)) % 4;   // Answer 1 to 4 cycles later
  endtask

  initial begin
    seed          = 32'h31b1_bcd3;
    memreq_rdy    = 1'b0;
    memresp_val   = 1'b0;
    memresp_msg   = '0;
    cacheresp_rdy = 1'b0;
    busy          = 1'b0;
    resp_taken    = 1'b0;
    delay         = 0;
    wb_count      = 0;
  end

  always @(negedge clk) begin
    if (resp_taken) begin
      memresp_val = 1'b0;
      busy        = 1'b0;
      resp_taken  = 1'b0;
    end else if (busy && !memresp_val) begin
      if (delay == 0) memresp_val = 1'b1;
      else delay = delay - 1;
    end
    memreq_rdy    = !busy && (($unsigned($random(seed)) % 4) != 0);   // Stalls now and then
    cacheresp_rdy = ($unsigned($random(seed)) % 4) != 0;   // Low about one cycle in four
    // Transfers that the coming rising edge makes
    if (memreq_val && memreq_rdy) accept_request(memreq_msg);
    if (memresp_val && memresp_rdy) resp_taken = 1'b1;
  end

endmodule

`default_nettype wire

// File: tb/cache_tb.sv
//------------------
// Cache testbench top with case reader, checks and watchdog
//------------------

`timescale 1ns/1ps
`default_nettype none

`include "cache_consts.svh"

module cache_tb;

  localparam string CASE_FILE       = "tb/cache_cases.txt";
  localparam int    MAX_CASES       = 64;
  localparam int    CYCLES_PER_CASE = 40;
  localparam int    HIT_LATENCY     = 3;    // tag_check, access, resp_wait
  localparam logic [`CACHE_DATA_W-1:0] FILL_KEY = 32'hA5A5_0000;

  logic                       clk;
  logic                       reset;
  logic                       cachereq_val;
  logic                       cachereq_rdy;
  cache_msg_pkg::cache_req_t  cachereq_msg;
  logic                       cacheresp_val;
  logic                       cacheresp_rdy;
  cache_msg_pkg::cache_resp_t cacheresp_msg;
  logic                       memreq_val;
  logic                       memreq_rdy;
  cache_msg_pkg::mem_req_t    memreq_msg;
  logic                       memresp_val;
  logic                       memresp_rdy;
  cache_msg_pkg::mem_resp_t   memresp_msg;

  // Cases as read from the file
  string                    case_name  [MAX_CASES];
  string                    case_kind  [MAX_CASES];
  logic [`CACHE_ADDR_W-1:0] case_addr  [MAX_CASES];
  logic [`CACHE_DATA_W-1:0] case_wdata [MAX_CASES];
  logic [`CACHE_DATA_W-1:0] case_exp   [MAX_CASES];
  logic                     case_hit   [MAX_CASES];
  int                       num_cases;
  logic                     cases_loaded;
  int                       wb_checked;

  blocking_cache dut_i (.*);

  cache_mem_model mem_i (
    .clk           (clk),
    .memreq_val    (memreq_val),
    .memreq_rdy    (memreq_rdy),
    .memreq_msg    (memreq_msg),
    .memresp_val   (memresp_val),
    .memresp_rdy   (memresp_rdy),
    .memresp_msg   (memresp_msg),
    .cacheresp_rdy (cacheresp_rdy)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("TEST FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  //------------------
  // Compare tasks
  //------------------

  task automatic check_resp(input string name, input cache_msg_pkg::cache_resp_t exp,
                            input cache_msg_pkg::cache_resp_t act);
    if (act !== exp) begin
      abort_run({$sformatf("MISMATCH %s: expected type %0d data %h hit %0b,",
                           name, exp.req_type, exp.data, exp.hit),
                 $sformatf(" actual type %0d data %h hit %0b",
                           act.req_type, act.data, act.hit)});
    end
  endtask

  task automatic check_mem(input string name, input cache_msg_pkg::mem_req_t exp,
                           input cache_msg_pkg::mem_req_t act);
    if (act !== exp) begin
      abort_run({$sformatf("MISMATCH %s: expected type %0d addr %h line %h,",
                           name, exp.mem_type, exp.addr, exp.data),
                 $sformatf(" actual type %0d addr %h line %h",
                           act.mem_type, act.addr, act.data)});
    end
  endtask

  task automatic check_latency(input string name, input int exp, input int act);
    if (act != exp) begin
      abort_run($sformatf("MISMATCH %s: expected latency %0d cycles, actual %0d cycles",
                          name, exp, act));
    end
  endtask

  // Handshake outputs of an idle cache, as {cachereq_rdy, cacheresp_val, memreq_val, memresp_rdy}
  task automatic check_idle_outputs(input string name);
    logic [3:0] act;
    act = {cachereq_rdy, cacheresp_val, memreq_val, memresp_rdy};
    if (act !== 4'b1000) begin
      abort_run($sformatf("MISMATCH %s: expected handshake bits 1000, actual %b", name, act));
    end
  endtask

  // Request port stays closed while a request is in flight
  task automatic check_port_closed(input int k);
    if (cachereq_rdy !== 1'b0) begin
      abort_run({"Request port was ready while ", case_name[k], " was in flight"});
    end
  endtask

  function automatic cache_msg_pkg::req_type_e req_type_of(input string kind);
    if (kind == "write") return cache_msg_pkg::req_write;
    if (kind == "init") return cache_msg_pkg::req_init;
    return cache_msg_pkg::req_read;
  endfunction

  task automatic load_cases();
    int    fd;
    int    code;
    int    hit;
    string tok;
    string kind;
    string rest;
    fd = $fopen(CASE_FILE, "r");
    if (fd == 0) abort_run({"Could not open the case file ", CASE_FILE});
    num_cases = 0;
    while (!$feof(fd)) begin
      code = $fscanf(fd, "%s", tok);
      if (code != 1) break;
      if (tok[0] == "#") begin
        code = $fgets(rest, fd);   // Column description line
      end else begin
        if (num_cases == MAX_CASES) abort_run("The case file holds too many cases");
        code = $fscanf(fd, "%s %h %h %h %d", kind, case_addr[num_cases],
                       case_wdata[num_cases], case_exp[num_cases], hit);
        if (code != 5) abort_run({"Case ", tok, " has missing or bad columns"});
        if (kind != "read" && kind != "write" && kind != "init" && kind != "wb") begin
          abort_run({"Case ", tok, " has an unknown kind ", kind});
        end
        case_name[num_cases] = tok;
        case_kind[num_cases] = kind;
        case_hit[num_cases]  = (hit != 0);
        num_cases++;
      end
    end
    $fclose(fd);
    if (num_cases == 0) abort_run("The case file holds no cases");
  endtask

  //------------------
  // Request and writeback cases
  //------------------

  // Called on a falling edge, returns on the falling edge after the response is taken
  task automatic run_request(input int k);
    cache_msg_pkg::cache_req_t  req;
    cache_msg_pkg::cache_resp_t exp_resp;
    cache_msg_pkg::cache_resp_t act_resp;
    int                         latency;
    req.req_type      = req_type_of(case_kind[k]);
    req.addr          = case_addr[k];
    req.data          = case_wdata[k];
    exp_resp.req_type = req.req_type;
    exp_resp.data     = case_exp[k];
    exp_resp.hit      = case_hit[k];
    cachereq_msg = req;
    cachereq_val = 1'b1;
    while (!cachereq_rdy) begin
      if (cacheresp_val) begin
        abort_run({"A response came with no request pending before ", case_name[k]});
      end
      @(negedge clk);
    end
    @(negedge clk);              // Request taken on the edge just passed
    cachereq_val = 1'b0;
    latency = 1;
    while (!cacheresp_val) begin
      check_port_closed(k);
      @(negedge clk);
      latency++;
    end
    act_resp = cacheresp_msg;
    while (cacheresp_val) begin
      check_port_closed(k);
      if (cacheresp_msg !== act_resp) begin
        abort_run({"Response changed while held for ", case_name[k]});
      end
      @(negedge clk);
    end
    check_resp(case_name[k], exp_resp, act_resp);
    if (case_hit[k] || req.req_type == cache_msg_pkg::req_init) begin
      check_latency(case_name[k], HIT_LATENCY, latency);
    end
  endtask

  // Old memory words with the one written word in place
  task automatic check_writeback(input int k);
    cache_msg_pkg::mem_req_t  exp_wb;
    logic [`CACHE_ADDR_W-1:0] word_addr;
    if (wb_checked >= mem_i.wb_count) abort_run({"No writeback was logged for ", case_name[k]});
    exp_wb.mem_type = cache_msg_pkg::mem_write;
    exp_wb.addr     = case_addr[k];
    for (int i = 0; i < `CACHE_WORDS; i++) begin
      word_addr = case_addr[k] + 4 * i;
      exp_wb.data[i*`CACHE_DATA_W +: `CACHE_DATA_W] =
        (word_addr == case_wdata[k]) ? case_exp[k] : (word_addr ^ FILL_KEY);
    end
    check_mem(case_name[k], exp_wb, mem_i.wb_log[wb_checked]);
    wb_checked++;
  endtask

  initial begin
    reset        = 1'b1;
    cachereq_val = 1'b0;
    cachereq_msg = '0;
    cases_loaded = 1'b0;
    wb_checked   = 0;
    load_cases();
    cases_loaded = 1'b1;
    repeat (4) @(posedge clk);
    @(negedge clk);
    check_idle_outputs("after_reset");
    reset = 1'b0;
    for (int k = 0; k < num_cases; k++) begin
      if (case_kind[k] == "wb") check_writeback(k);
      else run_request(k);
    end
    if (mem_i.wb_count != wb_checked) begin
      abort_run($sformatf("Memory logged %0d writebacks but %0d were expected",
                          mem_i.wb_count, wb_checked));
    end else begin
      $display("TEST PASSED");
      $finish;
    end
  end

  // Watchdog
  initial begin
    wait (cases_loaded);
    repeat (num_cases * CYCLES_PER_CASE + 8) @(posedge clk);
    abort_run($sformatf("Timed out after %0d cycles with cases still running",
                        num_cases * CYCLES_PER_CASE + 8));
  end

endmodule

`default_nettype wire
